//--- hdl/itf_beat_fifo.sv
/*
 * Single-clock FIFO with first-word fall-through
 * - register array storage
 * - pointers one bit wider than the address for full and empty
 */

`timescale 1ns/1ps

module itf_beat_fifo #(
    parameter int W  = 130,
    parameter int AW = 4
) (
    input  logic         clk,
    input  logic         rst_n,

    // Write side
    input  logic         push_i,
    input  logic [W-1:0] din_i,

    // Read side, head always visible
    input  logic         pop_i,
    output logic [W-1:0] dout_o,

    output logic         empty_o,
    output logic         full_o
);

    localparam int DEPTH = 1 << AW;

    // Beat storage
    logic [W-1:0] mem [DEPTH];

    logic [AW:0]  wr_ptr;
    logic [AW:0]  rd_ptr;
    logic         wr_en;
    logic         rd_en;

    // Ignore requests that would overflow or underflow
    assign wr_en = push_i && !full_o;
    assign rd_en = pop_i && !empty_o;

    // ====================
    // Storage write
    // ====================

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= din_i;
        end
    end

    // ====================
    // Pointers
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Same address, wrap bit tells full from empty
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW])
                  && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Head of queue
    assign dout_o = mem[rd_ptr[AW-1:0]];

endmodule

//--- hdl/itf_bus_mux.sv
/*
 * Bus direction gating
 * - off-chip ready and inbound push
 * - GIC ready, outbound push and pop
 * - pad data, valid and output enable
 */

`timescale 1ns/1ps

module itf_bus_mux
    import itf_types_pkg::*;
(
    input  dir_state_t state_i,

    // Inbound path
    input  logic       off_vld_i,
    input  logic       in_full_i,

    // Outbound FIFO
    input  out_word_t  out_head_i,
    input  logic       out_empty_i,
    input  logic       out_full_i,

    input  logic       dat_rdy_i,
    input  logic       gic_vld_i,

    output logic       off_rdy_o,
    output logic       in_push_o,
    output out_word_t  dat_o,
    output logic       dat_vld_o,
    output logic       dat_oe_o,
    output logic       out_pop_o,
    output logic       gic_rdy_o,
    output logic       out_push_o
);

    logic is_in;
    logic is_out;

    assign is_in  = (state_i == ST_IN) || (state_i == ST_IN_DRAIN);
    assign is_out = (state_i == ST_OUT) || (state_i == ST_OUT_DRAIN);

    // ====================
    // Inbound
    // ====================

    assign off_rdy_o = is_in && !in_full_i;
    assign in_push_o = off_rdy_o && off_vld_i;

    // ====================
    // Outbound
    // ====================

    assign gic_rdy_o  = is_out && !out_full_i;
    assign out_push_o = gic_rdy_o && gic_vld_i;

    // Pads driven only while turned outward
    assign dat_oe_o  = is_out;
    assign dat_o     = is_out ? out_head_i : '0;
    assign dat_vld_o = is_out && !out_empty_i;
    assign out_pop_o = dat_vld_o && dat_rdy_i;

endmodule

//--- hdl/itf_cfg_pkg.sv
/*
 * Interface sizing constants
 * - data beat width of the off-chip bus
 * - default FIFO address width
 */

package itf_cfg_pkg;

    // ====================
    // Data path
    // ====================

    // Width of one data beat on the off-chip bus
    localparam int PORT_W = 128;

    // ====================
    // Buffering
    // ====================

    // Default FIFO address width, 16 entries
    localparam int FIFO_AW_DEF = 4;

endpackage

//--- hdl/itf_dir_fsm.sv
/*
 * Transfer direction FSM
 * - picks inbound or outbound for the shared bus
 * - drains the active FIFO before turning around
 */

`timescale 1ns/1ps

module itf_dir_fsm
    import itf_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // Off-chip inbound request and accepted beat
    input  logic       off_vld_i,
    input  logic       off_last_i,
    input  logic       off_acc_i,

    // GIC outbound request and accepted beat
    input  logic       gic_vld_i,
    input  logic       gic_last_i,
    input  logic       gic_acc_i,

    // FIFO levels
    input  logic       in_empty_i,
    input  logic       out_empty_i,

    output dir_state_t state_o
);

    dir_state_t state_q;
    dir_state_t state_d;

    // ====================
    // Next state
    // ====================

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Off-chip wins over GIC
                if (off_vld_i) begin
                    state_d = ST_IN;
                end else if (gic_vld_i) begin
                    state_d = ST_OUT;
                end
            end
            ST_IN: begin
                // Last beat of the packet taken in
                if (off_acc_i && off_last_i) begin
                    state_d = ST_IN_DRAIN;
                end
            end
            ST_IN_DRAIN: begin
                // Last beat popped, bus free again
                if (in_empty_i) begin
                    state_d = ST_IDLE;
                end
            end
            ST_OUT: begin
                if (gic_acc_i && gic_last_i) begin
                    state_d = ST_OUT_DRAIN;
                end
            end
            ST_OUT_DRAIN: begin
                // Wait until everything left on the pads
                if (out_empty_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // ====================
    // State register
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

endmodule

//--- hdl/itf_in_route.sv
/*
 * Inbound router
 * - sends the inbound FIFO head to the CCU or the GIC
 * - pops on the chosen port's handshake
 */

`timescale 1ns/1ps

module itf_in_route
    import itf_cfg_pkg::*;
    import itf_types_pkg::*;
(
    input  dir_state_t        state_i,

    // Inbound FIFO head
    input  off_in_t           head_i,
    input  logic              empty_i,

    // Destination readies
    input  logic              isa_rdy_i,
    input  logic              gic_rdy_i,

    // CCU instruction port
    output logic [PORT_W-1:0] isa_dat_o,
    output logic              isa_vld_o,

    // GIC buffer port
    output gic_beat_t         gic_dat_o,
    output logic              gic_vld_o,

    output logic              pop_o
);

    logic head_vld;

    // Head is only offered while the bus runs inbound
    assign head_vld = ((state_i == ST_IN) || (state_i == ST_IN_DRAIN)) && !empty_i;

    // Steer by isa flag
    assign isa_vld_o = head_vld && head_i.isa;
    assign gic_vld_o = head_vld && !head_i.isa;

    assign isa_dat_o = head_i.data;

    // Inbound data never carries a command
    assign gic_dat_o.data = head_i.data;
    assign gic_dat_o.last = head_i.last;
    assign gic_dat_o.cmd  = 1'b0;

    // Only one of the two valids can be high
    assign pop_o = (isa_vld_o && isa_rdy_i) || (gic_vld_o && gic_rdy_i);

endmodule

//--- hdl/itf_top.sv
/*
 * Chip-edge transfer interface
 * - direction FSM, inbound and outbound FIFOs
 * - inbound router, bus direction gating
 */

`timescale 1ns/1ps

module itf_top
    import itf_cfg_pkg::*;
    import itf_types_pkg::*;
#(
    parameter int FIFO_AW = FIFO_AW_DEF
) (
    input  logic              clk,
    input  logic              rst_n,

    // Off-chip inbound
    input  logic              off_vld_i,
    input  off_in_t           off_beat_i,
    output logic              off_rdy_o,

    // Off-chip outbound
    output logic              dat_vld_o,
    output out_word_t         dat_o,
    input  logic              dat_rdy_i,
    output logic              dat_oe_o,

    // CCU instruction port
    output logic [PORT_W-1:0] isa_dat_o,
    output logic              isa_vld_o,
    input  logic              isa_rdy_i,

    // GIC inbound data
    output gic_beat_t         gic_in_o,
    output logic              gic_in_vld_o,
    input  logic              gic_in_rdy_i,

    // GIC outbound data
    input  gic_beat_t         gic_out_i,
    input  logic              gic_out_vld_i,
    output logic              gic_out_rdy_o
);

    dir_state_t state;

    // Inbound FIFO
    logic       in_push;
    logic       in_pop;
    off_in_t    in_head;
    logic       in_empty;
    logic       in_full;

    // Outbound FIFO
    logic       out_push;
    logic       out_pop;
    out_word_t  out_din;
    out_word_t  out_head;
    logic       out_empty;
    logic       out_full;

    // Last marker stays on chip
    assign out_din.data = gic_out_i.data;
    assign out_din.cmd  = gic_out_i.cmd;

    // ====================
    // Direction control
    // ====================

    itf_dir_fsm u_dir_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .off_vld_i   (off_vld_i),
        .off_last_i  (off_beat_i.last),
        .off_acc_i   (in_push),
        .gic_vld_i   (gic_out_vld_i),
        .gic_last_i  (gic_out_i.last),
        .gic_acc_i   (out_push),
        .in_empty_i  (in_empty),
        .out_empty_i (out_empty),
        .state_o     (state)
    );

    // ====================
    // FIFOs
    // ====================

    itf_beat_fifo #(
        .W  ($bits(off_in_t)),
        .AW (FIFO_AW)
    ) u_in_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (in_push),
        .din_i   (off_beat_i),
        .pop_i   (in_pop),
        .dout_o  (in_head),
        .empty_o (in_empty),
        .full_o  (in_full)
    );

    itf_beat_fifo #(
        .W  ($bits(out_word_t)),
        .AW (FIFO_AW)
    ) u_out_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (out_push),
        .din_i   (out_din),
        .pop_i   (out_pop),
        .dout_o  (out_head),
        .empty_o (out_empty),
        .full_o  (out_full)
    );

    // ====================
    // Routing and gating
    // ====================

    itf_in_route u_in_route (
        .state_i   (state),
        .head_i    (in_head),
        .empty_i   (in_empty),
        .isa_rdy_i (isa_rdy_i),
        .gic_rdy_i (gic_in_rdy_i),
        .isa_dat_o (isa_dat_o),
        .isa_vld_o (isa_vld_o),
        .gic_dat_o (gic_in_o),
        .gic_vld_o (gic_in_vld_o),
        .pop_o     (in_pop)
    );

    itf_bus_mux u_bus_mux (
        .state_i     (state),
        .off_vld_i   (off_vld_i),
        .in_full_i   (in_full),
        .out_head_i  (out_head),
        .out_empty_i (out_empty),
        .out_full_i  (out_full),
        .dat_rdy_i   (dat_rdy_i),
        .gic_vld_i   (gic_out_vld_i),
        .off_rdy_o   (off_rdy_o),
        .in_push_o   (in_push),
        .dat_o       (dat_o),
        .dat_vld_o   (dat_vld_o),
        .dat_oe_o    (dat_oe_o),
        .out_pop_o   (out_pop),
        .gic_rdy_o   (gic_out_rdy_o),
        .out_push_o  (out_push)
    );

endmodule

//--- hdl/itf_types_pkg.sv
/*
 * Transfer interface types
 * - inbound off-chip beat, GIC beat, outbound FIFO word
 * - direction state encoding
 */

package itf_types_pkg;

    import itf_cfg_pkg::*;

    // ====================
    // Beats
    // ====================

    // Off-chip inbound beat, also the inbound FIFO word
    typedef struct packed {
        logic [PORT_W-1:0] data;
        logic              last;
        // Set for instruction beats, clear for buffer data
        logic              isa;
    } off_in_t;

    // Beat to or from the global buffer controller
    typedef struct packed {
        logic [PORT_W-1:0] data;
        logic              last;
        logic              cmd;
    } gic_beat_t;

    // Outbound FIFO word, last is not carried off-chip
    typedef struct packed {
        logic [PORT_W-1:0] data;
        logic              cmd;
    } out_word_t;

    // ====================
    // Direction control
    // ====================

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_IN        = 3'd1,
        ST_IN_DRAIN  = 3'd2,
        ST_OUT       = 3'd3,
        ST_OUT_DRAIN = 3'd4
    } dir_state_t;

endpackage

//--- sources.f
hdl/itf_cfg_pkg.sv
hdl/itf_types_pkg.sv
hdl/itf_dir_fsm.sv
hdl/itf_beat_fifo.sv
hdl/itf_in_route.sv
hdl/itf_bus_mux.sv
hdl/itf_top.sv
test/itf_checker.sv
test/tb_itf.sv

//--- test/itf_checker.sv
/*
 * Output checker for the transfer interface
 * - expected beat queues filled by the testbench model
 * - handshake compares and bus direction rules
 * - per-test result lines and run totals
 */

`timescale 1ns/1ps

module itf_checker
    import itf_cfg_pkg::*;
    import itf_types_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic [PORT_W-1:0] isa_dat_i,
    input logic              isa_vld_i,
    input logic              isa_rdy_i,
    input gic_beat_t         gic_in_i,
    input logic              gic_in_vld_i,
    input logic              gic_in_rdy_i,
    input out_word_t         dat_i,
    input logic              dat_vld_i,
    input logic              dat_rdy_i,
    input logic              dat_oe_i,
    input logic              off_rdy_i,
    input logic              gic_out_rdy_i
);

    // Expected beats per destination
    logic [PORT_W-1:0] isa_q[$];
    gic_beat_t         gic_q[$];
    out_word_t         out_q[$];

    string test_name = "none";
    int    test_errs = 0;
    int    test_beats = 0;
    int    test_cnt = 0;
    int    fail_tests = 0;
    int    err_cnt = 0;
    int    beat_cnt = 0;

    // ====================
    // Model interface
    // ====================

    task automatic expect_isa(input logic [PORT_W-1:0] d);
        isa_q.push_back(d);
    endtask

    task automatic expect_gic(input gic_beat_t b);
        gic_q.push_back(b);
    endtask

    task automatic expect_out(input out_word_t w);
        out_q.push_back(w);
    endtask

    function automatic int pending();
        return isa_q.size() + gic_q.size() + out_q.size();
    endfunction

    // ====================
    // Reporting
    // ====================

    task automatic note_error(input string msg);
        $display("Error in test %s at %0t: %s", test_name, $time, msg);
        test_errs++;
        err_cnt++;
    endtask

    task automatic compare_word(input string port, input logic [129:0] exp,
                                input logic [129:0] act);
        test_beats++;
        beat_cnt++;
        if (act !== exp) begin
            $display("[FAIL] %s %s expected %h actual %h", test_name, port, exp, act);
            test_errs++;
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_errs  = 0;
        test_beats = 0;
    endtask

    task automatic end_test();
        // Anything left here never reached its port
        if (pending() != 0) begin
            note_error($sformatf("%0d expected beats never delivered", pending()));
        end
        test_cnt++;
        if (test_errs != 0) begin
            fail_tests++;
        end
        $display("Test %s done: %0d checks, %0d errors", test_name, test_beats, test_errs);
    endtask

    // ====================
    // Watch the DUT
    // ====================

    always @(posedge clk) begin
        if (rst_n) begin
            // Direction rules first, before this edge's pops
            if (dat_vld_i && !dat_oe_i) begin
                note_error("dat_vld_o high while dat_oe_o is low");
            end
            if (off_rdy_i && dat_oe_i) begin
                note_error("off_rdy_o high while the bus drives out");
            end
            if (gic_out_rdy_i && (isa_vld_i || gic_in_vld_i || off_rdy_i)) begin
                note_error("gic_out_rdy_o high during an inbound packet");
            end
            if (dat_oe_i && (isa_q.size() + gic_q.size()) != 0) begin
                note_error("bus turned out before inbound beats left");
            end
            if (off_rdy_i && out_q.size() != 0) begin
                note_error("bus turned in before outbound beats left");
            end
            // Output handshakes against the model queues
            if (isa_vld_i && isa_rdy_i) begin
                if (isa_q.size() == 0) begin
                    note_error("unexpected beat on isa_dat_o");
                end else begin
                    compare_word("isa_dat_o", isa_q.pop_front(), isa_dat_i);
                end
            end
            if (gic_in_vld_i && gic_in_rdy_i) begin
                if (gic_q.size() == 0) begin
                    note_error("unexpected beat on gic_in_o");
                end else begin
                    compare_word("gic_in_o", gic_q.pop_front(), gic_in_i);
                end
            end
            if (dat_vld_i && dat_rdy_i) begin
                if (out_q.size() == 0) begin
                    note_error("unexpected beat on dat_o");
                end else begin
                    compare_word("dat_o", out_q.pop_front(), dat_i);
                end
            end
        end
    end

endmodule

//--- test/tb_itf.sv
/*
 * Testbench for the transfer interface
 * - clock, reset, xorshift stimulus and random readies
 * - reference model feeding the checker queues
 * - cycle limit and closing summary
 */

`timescale 1ns/1ps

module tb_itf
    import itf_cfg_pkg::*;
    import itf_types_pkg::*;
();

    localparam logic [31:0] SEED = 32'h7028_a2a6;
    localparam int NUM_PKTS = 60;
    localparam int MAX_LEN  = 6;
    // Shallow FIFOs so that packets fill them
    localparam int FIFO_AW  = 2;
    // Worst case per packet incl. turnaround
    localparam int LIMIT    = NUM_PKTS * (MAX_LEN * 8 + 20);
    localparam int DRAIN_LIMIT = 2 * (MAX_LEN * 8 + 20);

    logic              clk = 1'b0;
    logic              rst_n;
    logic              off_vld_i;
    off_in_t           off_beat_i;
    logic              off_rdy_o;
    logic              dat_vld_o;
    out_word_t         dat_o;
    logic              dat_rdy_i;
    logic              dat_oe_o;
    logic [PORT_W-1:0] isa_dat_o;
    logic              isa_vld_o;
    logic              isa_rdy_i;
    gic_beat_t         gic_in_o;
    logic              gic_in_vld_o;
    logic              gic_in_rdy_i;
    gic_beat_t         gic_out_i;
    logic              gic_out_vld_i;
    logic              gic_out_rdy_o;

    logic [31:0]       stim_rng = SEED;
    logic [31:0]       rdy_rng = ~SEED;
    logic              slow_rdy = 1'b0;
    int                cycles = 0;

    always #10 clk = ~clk;

    itf_top #(.FIFO_AW(FIFO_AW)) i_dut (
        .clk(clk), .rst_n(rst_n),
        .off_vld_i(off_vld_i), .off_beat_i(off_beat_i), .off_rdy_o(off_rdy_o),
        .dat_vld_o(dat_vld_o), .dat_o(dat_o), .dat_rdy_i(dat_rdy_i), .dat_oe_o(dat_oe_o),
        .isa_dat_o(isa_dat_o), .isa_vld_o(isa_vld_o), .isa_rdy_i(isa_rdy_i),
        .gic_in_o(gic_in_o), .gic_in_vld_o(gic_in_vld_o), .gic_in_rdy_i(gic_in_rdy_i),
        .gic_out_i(gic_out_i), .gic_out_vld_i(gic_out_vld_i), .gic_out_rdy_o(gic_out_rdy_o)
    );

    itf_checker u_checker (
        .clk(clk), .rst_n(rst_n),
        .isa_dat_i(isa_dat_o), .isa_vld_i(isa_vld_o), .isa_rdy_i(isa_rdy_i),
        .gic_in_i(gic_in_o), .gic_in_vld_i(gic_in_vld_o), .gic_in_rdy_i(gic_in_rdy_i),
        .dat_i(dat_o), .dat_vld_i(dat_vld_o), .dat_rdy_i(dat_rdy_i), .dat_oe_i(dat_oe_o),
        .off_rdy_i(off_rdy_o), .gic_out_rdy_i(gic_out_rdy_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        stim_rng = xorshift32(stim_rng);
        r = stim_rng;
    endtask

    // ====================
    // Readies and model
    // ====================

    // Ready high 3 in 4, or 1 in 4 when slowed
    always @(negedge clk) begin
        rdy_rng = xorshift32(rdy_rng);
        isa_rdy_i    <= slow_rdy ? (rdy_rng[1:0] == 2'd0) : (rdy_rng[1:0] != 2'd0);
        gic_in_rdy_i <= slow_rdy ? (rdy_rng[3:2] == 2'd0) : (rdy_rng[3:2] != 2'd0);
        dat_rdy_i    <= slow_rdy ? (rdy_rng[5:4] == 2'd0) : (rdy_rng[5:4] != 2'd0);
    end

    // Every accepted beat goes to the queue of its destination
    always @(posedge clk) begin
        if (rst_n && off_vld_i && off_rdy_o) begin
            if (off_beat_i.isa) begin
                u_checker.expect_isa(off_beat_i.data);
            end else begin
                u_checker.expect_gic({off_beat_i.data, off_beat_i.last, 1'b0});
            end
        end
        if (rst_n && gic_out_vld_i && gic_out_rdy_o) begin
            u_checker.expect_out({gic_out_i.data, gic_out_i.cmd});
        end
    end

    // ====================
    // Stimulus
    // ====================

    // isa_mode 0 clear, 1 set, 2 random per beat
    task automatic send_packet(input logic outbound, input int len, input int isa_mode);
        logic [PORT_W-1:0] data;
        logic [31:0]       r;
        for (int i = 0; i < len; i++) begin
            for (int w = 0; w < PORT_W / 32; w++) begin
                next_rand(r);
                data[w*32 +: 32] = r;
            end
            next_rand(r);
            // Source gap now and then
            if (r[3:2] == 2'd0) begin
                @(negedge clk);
                off_vld_i     <= 1'b0;
                gic_out_vld_i <= 1'b0;
            end
            @(negedge clk);
            if (outbound) begin
                gic_out_vld_i <= 1'b1;
                gic_out_i     <= {data, i == len - 1, r[0]};
            end else begin
                off_vld_i  <= 1'b1;
                off_beat_i <= {data, i == len - 1, (isa_mode == 2) ? r[1] : isa_mode[0]};
            end
            do @(posedge clk);
            while (!((off_vld_i && off_rdy_o) || (gic_out_vld_i && gic_out_rdy_o)));
        end
        // Next packet may be requested while this one still drains
        @(negedge clk);
        off_vld_i     <= 1'b0;
        gic_out_vld_i <= 1'b0;
    endtask

    // kind 0 isa inbound, 1 gic inbound, 2 outbound, 3 random mix
    task automatic run_test(input string name, input int pkts, input int kind);
        logic [31:0] r;
        int          len;
        int          wait_cyc;
        u_checker.start_test(name);
        for (int p = 0; p < pkts; p++) begin
            next_rand(r);
            len = r % MAX_LEN + 1;
            if (kind == 3) begin
                send_packet(r[8], len, 2);
            end else begin
                send_packet(kind == 2, len, (kind == 0) ? 1 : 0);
            end
        end
        // Let the last packet leave, bounded
        wait_cyc = 0;
        while (u_checker.pending() != 0 && wait_cyc < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cyc++;
        end
        u_checker.end_test();
    endtask

    initial begin
        rst_n         = 1'b0;
        off_vld_i     = 1'b0;
        off_beat_i    = '0;
        dat_rdy_i     = 1'b0;
        isa_rdy_i     = 1'b0;
        gic_in_rdy_i  = 1'b0;
        gic_out_i     = '0;
        gic_out_vld_i = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Idle outputs before any request
        u_checker.start_test("reset_outputs");
        repeat (4) begin
            @(negedge clk);
            u_checker.compare_word("control outputs", '0,
                {off_rdy_o, dat_vld_o, dat_oe_o, isa_vld_o, gic_in_vld_o, gic_out_rdy_o});
        end
        u_checker.end_test();
        run_test("inbound_isa", 10, 0);
        run_test("inbound_gic", 10, 1);
        run_test("outbound", 10, 2);
        slow_rdy = 1'b1;
        run_test("backpressure", 30, 3);
        $display("Tests %0d, failed %0d, checks %0d, errors %0d", u_checker.test_cnt,
                 u_checker.fail_tests, u_checker.beat_cnt, u_checker.err_cnt);
        if (u_checker.err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Cycle limit
    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d beats pending", cycles, u_checker.pending());
        $display("Finished with errors");
        $finish;
    end

endmodule
